/* Makefile */
TOP := tb_rv32m_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir

/* files.f */
verilog/rv32m_pkg.sv
verilog/m_req_if.sv
verilog/m_raw_if.sv
verilog/m_mul_pipe.sv
verilog/m_div_iter.sv
verilog/m_result_merge.sv
verilog/rv32m_unit.sv
testbench/rv32m_checker.sv
testbench/tb_rv32m_unit.sv

/* testbench/rv32m_checker.sv */
`timescale 1ns/1ps

module rv32m_checker (
   input logic CLK,
   input logic RST_N,
   input logic mul_valid,
   input logic div_valid,
   input logic ready
);

   // the issue rule and the unit latencies keep the raw strobes apart
   a_one_source: assert property (
      @(posedge CLK) disable iff (!RST_N)
      !(mul_valid && div_valid)
   ) else $error("multiplier and divider raw valids high in the same cycle");

   a_ready_reset: assert property (
      @(posedge CLK)
      !RST_N |=> !ready
   ) else $error("ready is high after a reset cycle");

   a_valid_ready: assert property (
      @(posedge CLK) disable iff (!RST_N)
      (mul_valid || div_valid) |=> ready
   ) else $error("raw valid was not followed by ready");

endmodule

bind m_result_merge rv32m_checker i_checker (
   .CLK       (CLK),
   .RST_N     (RST_N),
   .mul_valid (mul_res.valid),
   .div_valid (div_res.valid),
   .ready     (ready)
);

/* testbench/tb_rv32m_unit.sv */
`timescale 1ns/1ps

module tb_rv32m_unit;

   localparam int WAIT_LIMIT = rv32m_pkg::DIV_STEPS + 8;

   logic                         CLK;
   logic                         RST_N;
   logic                         issue;
   logic [2:0]                   op;
   logic [rv32m_pkg::XLEN-1:0]   rs1;
   logic [rv32m_pkg::XLEN-1:0]   rs2;
   logic                         busy;
   logic                         ready;
   logic [rv32m_pkg::XLEN-1:0]   rd;

   logic [rv32m_pkg::XLEN-1:0]   exp_q [$];   // results in issue order
   int                           accepted_cnt;
   int                           ready_cnt;
   int                           fail_cnt;

   rv32m_unit i_dut (
      .CLK   (CLK),
      .RST_N (RST_N),
      .issue (issue),
      .op    (op),
      .rs1   (rs1),
      .rs2   (rs2),
      .busy  (busy),
      .ready (ready),
      .rd    (rd)
   );

   always #2 CLK = ~CLK;

   task automatic stop_with_failure();
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic report_failure(input string msg);
      fail_cnt++;
      $display("Error at time %0t: %s", $time, msg);
      stop_with_failure();
   endtask

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         fail_cnt++;
         $display("Mismatch at time %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
         stop_with_failure();
      end
   endtask

   // 64-bit arithmetic with the RISC-V rules for a zero divisor and overflow
   function automatic logic [31:0] ref_result(input logic [2:0] f3, input logic [31:0] a,
                                              input logic [31:0] b);
      logic signed [63:0] sa;
      logic signed [63:0] sb;
      logic        [63:0] ua;
      logic        [63:0] ub;
      logic        [63:0] p;
      logic               ovf;
      logic        [31:0] r;
      sa  = {{32{a[31]}}, a};
      sb  = {{32{b[31]}}, b};
      ua  = {32'b0, a};
      ub  = {32'b0, b};
      ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
      r   = '0;
      case (f3)
         rv32m_pkg::OP_MUL: begin
            p = sa * sb;
            r = p[31:0];
         end
         rv32m_pkg::OP_MULH: begin
            p = sa * sb;
            r = p[63:32];
         end
         rv32m_pkg::OP_MULHSU: begin
            p = sa * $signed(ub);
            r = p[63:32];
         end
         rv32m_pkg::OP_MULHU: begin
            p = ua * ub;
            r = p[63:32];
         end
         rv32m_pkg::OP_DIV: begin
            if (b == 0) begin
               r = '1;
            end else if (ovf) begin
               r = a;
            end else begin
               p = sa / sb;
               r = p[31:0];
            end
         end
         rv32m_pkg::OP_DIVU: begin
            if (b == 0) begin
               r = '1;
            end else begin
               p = ua / ub;
               r = p[31:0];
            end
         end
         rv32m_pkg::OP_REM: begin
            if (b == 0) begin
               r = a;
            end else if (ovf) begin
               r = '0;
            end else begin
               p = sa % sb;   // sign follows the dividend
               r = p[31:0];
            end
         end
         default: begin
            if (b == 0) begin
               r = a;
            end else begin
               p = ua % ub;
               r = p[31:0];
            end
         end
      endcase
      return r;
   endfunction

   function automatic logic [31:0] edge_value(input int idx);
      logic [31:0] v;
      case (idx)
         0:       v = 32'h0000_0000;
         1:       v = 32'h0000_0001;
         2:       v = 32'hffff_ffff;
         default: v = 32'h8000_0000;
      endcase
      return v;
   endfunction

   function automatic logic [31:0] pick_operand();
      logic [31:0] v;
      v = $urandom();
      if ($urandom_range(3, 0) == 0) v = edge_value(int'($urandom_range(3, 0)));
      return v;
   endfunction

   function automatic logic [31:0] signed_operand(input logic neg);
      logic [31:0] v;
      v     = $urandom();
      v[31] = neg;
      return v;
   endfunction

   // called 0.5 ns after a rising edge, returns 0.5 ns after the next one
   task automatic drive_issue(input logic [2:0] o, input logic [31:0] a, input logic [31:0] b);
      issue = 1'b1;
      op    = o;
      rs1   = a;
      rs2   = b;
      if (!busy) begin
         exp_q.push_back(ref_result(o, a, b));
         accepted_cnt++;
      end
      @(posedge CLK);
      #0.5;
      issue = 1'b0;
   endtask

   // busy stays high for one cycle per quotient bit after the divide is accepted
   task automatic wait_not_busy();
      int cnt;
      cnt = 0;
      while (busy && cnt < WAIT_LIMIT) begin
         @(posedge CLK);
         #0.5;
         cnt++;
      end
      if (busy) report_failure("busy did not fall after a divide");
      check_value("busy cycles", cnt, rv32m_pkg::DIV_STEPS);
   endtask

   // every issue in here lands on a busy divider and must be dropped
   task automatic issue_while_busy();
      int cnt;
      cnt = 0;
      while (busy && cnt < WAIT_LIMIT) begin
         drive_issue(3'($urandom_range(7, 0)), $urandom(), $urandom());
         cnt++;
      end
      if (busy) report_failure("busy did not fall while issuing into a busy divider");
   endtask

   task automatic wait_drained();
      int cnt;
      cnt = 0;
      while (exp_q.size() != 0 && cnt < WAIT_LIMIT) begin
         @(posedge CLK);
         #0.5;
         cnt++;
      end
      if (exp_q.size() != 0) report_failure("expected results still outstanding at the end");
   endtask

   initial begin
      logic [31:0] exp;
      forever begin
         @(negedge CLK);
         if (RST_N && ready) begin
            ready_cnt++;
            if (exp_q.size() == 0) begin
               report_failure("ready pulse with no outstanding issue");
            end else begin
               exp = exp_q.pop_front();
               check_value("rd", rd, exp);
            end
         end
      end
   end

   initial begin
      CLK          = 1'b0;
      RST_N        = 1'b0;
      issue        = 1'b0;
      op           = '0;
      rs1          = '0;
      rs2          = '0;
      accepted_cnt = 0;
      ready_cnt    = 0;
      fail_cnt     = 0;
      void'($urandom(12857));
      repeat (3) @(posedge CLK);
      #0.5;
      RST_N = 1'b1;
      check_value("busy", 32'(busy), 32'd0);
      check_value("ready", 32'(ready), 32'd0);
      check_value("rd", rd, 32'd0);

      for (int i = 0; i < 4; i++) begin
         for (int j = 0; j < 4; j++) begin
            drive_issue(rv32m_pkg::OP_MUL, edge_value(i), edge_value(j));
         end
      end
      repeat (16) drive_issue(rv32m_pkg::OP_MUL, $urandom(), $urandom());

      for (int f = 1; f <= 3; f++) begin
         for (int s = 0; s < 4; s++) begin
            repeat (3) drive_issue(3'(f), signed_operand(s[1]), signed_operand(s[0]));
         end
      end

      for (int f = 4; f <= 7; f++) begin
         repeat (6) begin
            drive_issue(3'(f), $urandom(), $urandom() >> $urandom_range(28, 0));
            wait_not_busy();
         end
      end

      for (int f = 4; f <= 7; f++) begin
         drive_issue(3'(f), $urandom(), 32'd0);
         wait_not_busy();
         drive_issue(3'(f), 32'h8000_0000, 32'd0);
         wait_not_busy();
         drive_issue(3'(f), 32'h8000_0000, 32'hffff_ffff);   // overflow for the signed ops
         wait_not_busy();
      end

      repeat (8) drive_issue(3'($urandom_range(3, 0)), pick_operand(), pick_operand());
      drive_issue(rv32m_pkg::OP_DIV, pick_operand(), pick_operand());
      wait_not_busy();
      repeat (4) drive_issue(3'($urandom_range(3, 0)), pick_operand(), pick_operand());
      drive_issue(rv32m_pkg::OP_REMU, $urandom(), $urandom_range(255, 1));
      wait_not_busy();
      drive_issue(rv32m_pkg::OP_DIVU, $urandom(), $urandom_range(255, 1));   // issued in DIV_DONE
      wait_not_busy();
      drive_issue(rv32m_pkg::OP_MULHU, $urandom(), $urandom());

      drive_issue(rv32m_pkg::OP_REM, $urandom(), $urandom());
      issue_while_busy();
      repeat (60) begin
         drive_issue(3'($urandom_range(7, 0)), pick_operand(), pick_operand());
         if ($urandom_range(3, 0) == 0) begin
            @(posedge CLK);
            #0.5;
         end
      end

      wait_drained();
      repeat (4) @(posedge CLK);
      check_value("ready count", ready_cnt, accepted_cnt);
      if (fail_cnt == 0 && exp_q.size() == 0) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         stop_with_failure();
      end
   end

endmodule

/* verilog/m_div_iter.sv */
`timescale 1ns/1ps

module m_div_iter (
   input logic   CLK,
   input logic   RST_N,
   m_req_if.div  req,
   m_raw_if.unit res
);

   rv32m_pkg::div_state_e          state;
   rv32m_pkg::m_op_e               op_q;
   logic                           sign_q;
   logic [rv32m_pkg::XLEN-1:0]     dividend;    // ends up holding the remainder
   logic [rv32m_pkg::DIVR_W-1:0]   divisor;
   logic [rv32m_pkg::XLEN-1:0]     quotient;
   logic [rv32m_pkg::XLEN-1:0]     q_mask;
   logic                           start;
   logic                           op_signed;
   logic                           rs1_neg;
   logic                           rs2_neg;
   logic [rv32m_pkg::XLEN-1:0]     rs1_mag;
   logic [rv32m_pkg::XLEN-1:0]     rs2_mag;
   logic                           sign_next;
   logic                           fits;

   // a new divide can start while the previous one is presenting its result
   assign start = req.issue && rv32m_pkg::is_div_op(req.op) &&
                  (state != rv32m_pkg::DIV_EXEC);

   assign op_signed = (req.op == rv32m_pkg::OP_DIV) || (req.op == rv32m_pkg::OP_REM);
   assign rs1_neg   = op_signed && req.rs1[rv32m_pkg::XLEN-1];
   assign rs2_neg   = op_signed && req.rs2[rv32m_pkg::XLEN-1];
   assign rs1_mag   = rs1_neg ? -req.rs1 : req.rs1;
   assign rs2_mag   = rs2_neg ? -req.rs2 : req.rs2;

   // a zero divisor keeps the all-ones quotient unsigned
   assign sign_next = ((req.op == rv32m_pkg::OP_DIV) && (rs1_neg ^ rs2_neg) && (|req.rs2)) ||
                      ((req.op == rv32m_pkg::OP_REM) && rs1_neg);

   assign fits = divisor <= {{(rv32m_pkg::DIVR_W-rv32m_pkg::XLEN){1'b0}}, dividend};

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         state <= rv32m_pkg::DIV_IDLE;
      end else begin
         case (state)
            rv32m_pkg::DIV_EXEC: begin
               if (q_mask[0]) begin
                  state <= rv32m_pkg::DIV_DONE;   // last quotient bit resolved this edge
               end
            end
            default: begin
               if (start) begin
                  state <= rv32m_pkg::DIV_EXEC;
               end else begin
                  state <= rv32m_pkg::DIV_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge CLK) begin
      if (start) begin
         dividend <= rs1_mag;
         divisor  <= {rs2_mag, {(rv32m_pkg::DIV_STEPS-1){1'b0}}};
         quotient <= '0;
         q_mask   <= {1'b1, {(rv32m_pkg::XLEN-1){1'b0}}};
         op_q     <= req.op;
         sign_q   <= sign_next;
      end else if (state == rv32m_pkg::DIV_EXEC) begin
         if (fits) begin
            dividend <= dividend - divisor[rv32m_pkg::XLEN-1:0];   // upper bits are zero here
            quotient <= quotient | q_mask;
         end
         divisor <= divisor >> 1;
         q_mask  <= q_mask >> 1;
      end
   end

   assign req.busy   = (state == rv32m_pkg::DIV_EXEC);
   assign res.valid  = (state == rv32m_pkg::DIV_DONE);
   assign res.op     = op_q;
   assign res.raw    = {dividend, quotient};
   assign res.negate = sign_q;

endmodule

/* verilog/m_mul_pipe.sv */
`timescale 1ns/1ps

module m_mul_pipe (
   input logic   CLK,
   input logic   RST_N,
   m_req_if.mul  req,
   m_raw_if.unit res
);

   logic                                 accept;
   logic                                 a_signed;
   logic                                 b_signed;
   logic                                 s1_valid;
   rv32m_pkg::m_op_e                     s1_op;
   logic signed [rv32m_pkg::XLEN:0]      s1_a;
   logic signed [rv32m_pkg::XLEN:0]      s1_b;
   logic signed [2*rv32m_pkg::XLEN+1:0]  product;
   logic                                 s2_valid;
   rv32m_pkg::m_op_e                     s2_op;
   logic [2*rv32m_pkg::XLEN-1:0]         s2_prod;

   assign accept   = req.issue && !req.busy && !rv32m_pkg::is_div_op(req.op);
   assign a_signed = (req.op == rv32m_pkg::OP_MULH) || (req.op == rv32m_pkg::OP_MULHSU);
   assign b_signed = (req.op == rv32m_pkg::OP_MULH);

   // 33x33 signed covers every signed/unsigned mix
   assign product = s1_a * s1_b;

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else begin
         s1_valid <= accept;
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge CLK) begin
      if (accept) begin
         s1_a  <= {a_signed & req.rs1[rv32m_pkg::XLEN-1], req.rs1};
         s1_b  <= {b_signed & req.rs2[rv32m_pkg::XLEN-1], req.rs2};
         s1_op <= req.op;
      end
      s2_prod <= product[2*rv32m_pkg::XLEN-1:0];   // upper two bits are only sign copies
      s2_op   <= s1_op;
   end

   assign res.valid  = s2_valid;
   assign res.op     = s2_op;
   assign res.raw    = s2_prod;
   assign res.negate = 1'b0;

endmodule

/* verilog/m_raw_if.sv */
`timescale 1ns/1ps

interface m_raw_if;

   logic                           valid;    // one-cycle strobe, never stalled
   rv32m_pkg::m_op_e               op;
   logic [2*rv32m_pkg::XLEN-1:0]   raw;
   logic                           negate;   // selected word must be two's complemented

   modport unit (
      output valid, op, raw, negate
   );

   modport merge (
      input valid, op, raw, negate
   );

endinterface

/* verilog/m_req_if.sv */
`timescale 1ns/1ps

interface m_req_if;

   logic                         issue;   // one-cycle strobe
   rv32m_pkg::m_op_e             op;
   logic [rv32m_pkg::XLEN-1:0]   rs1;
   logic [rv32m_pkg::XLEN-1:0]   rs2;
   logic                         busy;    // divider iterating, issues dropped

   modport source (
      output issue, op, rs1, rs2,
      input  busy
   );

   modport mul (
      input issue, op, rs1, rs2, busy
   );

   modport div (
      input  issue, op, rs1, rs2,
      output busy
   );

endinterface

/* verilog/m_result_merge.sv */
`timescale 1ns/1ps

module m_result_merge (
   input  logic                         CLK,
   input  logic                         RST_N,
   m_raw_if.merge                       mul_res,
   m_raw_if.merge                       div_res,
   output logic                         ready,
   output logic [rv32m_pkg::XLEN-1:0]   rd
);

   logic                           src_valid;
   rv32m_pkg::m_op_e               src_op;
   logic [2*rv32m_pkg::XLEN-1:0]   src_raw;
   logic                           src_neg;
   logic [rv32m_pkg::XLEN-1:0]     word;
   logic [rv32m_pkg::XLEN-1:0]     result;

   assign src_valid = mul_res.valid || div_res.valid;

   // the two units never strobe in the same cycle
   always_comb begin
      if (mul_res.valid) begin
         src_op  = mul_res.op;
         src_raw = mul_res.raw;
         src_neg = mul_res.negate;
      end else begin
         src_op  = div_res.op;
         src_raw = div_res.raw;
         src_neg = div_res.negate;
      end
   end

   assign word = rv32m_pkg::hi_word(src_op) ?
                 src_raw[2*rv32m_pkg::XLEN-1:rv32m_pkg::XLEN] :
                 src_raw[rv32m_pkg::XLEN-1:0];

   assign result = src_neg ? -word : word;   // divider sign fix-up

   always_ff @(posedge CLK) begin
      if (!RST_N) begin
         ready <= 1'b0;
         rd    <= '0;
      end else begin
         ready <= src_valid;
         if (src_valid) begin
            rd <= result;   // holds between results
         end
      end
   end

endmodule

/* verilog/rv32m_pkg.sv */
package rv32m_pkg;

   localparam int XLEN      = 32;
   localparam int DIV_STEPS = 32;
   localparam int DIVR_W    = XLEN + DIV_STEPS - 1;   // divisor slides down from bit 31 to bit 0

   // codes follow funct3 of the M extension
   typedef enum logic [2:0] {
      OP_MUL    = 3'd0,
      OP_MULH   = 3'd1,
      OP_MULHSU = 3'd2,
      OP_MULHU  = 3'd3,
      OP_DIV    = 3'd4,
      OP_DIVU   = 3'd5,
      OP_REM    = 3'd6,
      OP_REMU   = 3'd7
   } m_op_e;

   typedef enum logic [1:0] {
      DIV_IDLE = 2'd0,
      DIV_EXEC = 2'd1,
      DIV_DONE = 2'd2
   } div_state_e;

   function automatic logic is_div_op(input m_op_e op);
      return op[2];   // funct3 bit 2 splits divider from multiplier
   endfunction

   // the result lives in the upper half of the raw word for
   // the high-product operations and for the remainder
   function automatic logic hi_word(input m_op_e op);
      logic hi;
      case (op)
         OP_MULH, OP_MULHSU, OP_MULHU: hi = 1'b1;
         OP_REM, OP_REMU:              hi = 1'b1;
         default:                      hi = 1'b0;
      endcase
      return hi;
   endfunction

endpackage

/* verilog/rv32m_unit.sv */
`timescale 1ns/1ps

module rv32m_unit (
   input  logic                         CLK,
   input  logic                         RST_N,
   input  logic                         issue,
   input  logic [2:0]                   op,
   input  logic [rv32m_pkg::XLEN-1:0]   rs1,
   input  logic [rv32m_pkg::XLEN-1:0]   rs2,
   output logic                         busy,
   output logic                         ready,
   output logic [rv32m_pkg::XLEN-1:0]   rd
);

   m_req_if req_bus ();
   m_raw_if mul_raw ();
   m_raw_if div_raw ();

   assign req_bus.issue = issue;
   assign req_bus.op    = rv32m_pkg::m_op_e'(op);   // funct3 maps straight onto the enum
   assign req_bus.rs1   = rs1;
   assign req_bus.rs2   = rs2;
   assign busy          = req_bus.busy;

   m_mul_pipe i_mul (
      .CLK   (CLK),
      .RST_N (RST_N),
      .req   (req_bus.mul),
      .res   (mul_raw.unit)
   );

   m_div_iter i_div (
      .CLK   (CLK),
      .RST_N (RST_N),
      .req   (req_bus.div),
      .res   (div_raw.unit)
   );

   m_result_merge i_merge (
      .CLK     (CLK),
      .RST_N   (RST_N),
      .mul_res (mul_raw.merge),
      .div_res (div_raw.merge),
      .ready   (ready),
      .rd      (rd)
   );

endmodule
